// ==== rtl/lsu_pkg.sv ====
/*
 * Load-store unit shared definitions
 * Opcodes, FSM states, exception codes, core and memory bus structs,
 * and the sizing constants of the subsystem
 */

package lsu_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////
  localparam int DATA_W      = 32;  // Data and address width
  localparam int REG_AW      = 5;   // Destination register index
  localparam int RAM_WORDS   = 256; // 1 KiB of data RAM
  localparam int RAM_AW      = 8;   // Word index width
  localparam int BUS_TIMEOUT = 8;   // Cycles without ack before bus error
  localparam int TMR_W       = $clog2(BUS_TIMEOUT + 1); // Timer counter width

  ////////////////////////////////////////////////////////////
  // Enums
  ////////////////////////////////////////////////////////////
  // Stores occupy the top codes 101..111, so decode with is_store()
  typedef enum logic [2:0] {
    OP_LB  = 3'b000,
    OP_LBU = 3'b001,
    OP_LH  = 3'b010,
    OP_LHU = 3'b011,
    OP_LW  = 3'b100,
    OP_SB  = 3'b101,
    OP_SH  = 3'b110,
    OP_SW  = 3'b111
  } lsu_op_e;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0, // Waiting for a request
    ST_BUS  = 2'd1, // Strobe cycle
    ST_WAIT = 2'd2, // Waiting for ack or timeout
    ST_RESP = 2'd3  // Response held until taken
  } lsu_state_e;

  typedef enum logic [1:0] {
    EXC_NONE      = 2'd0,
    EXC_MIS_LOAD  = 2'd1,
    EXC_MIS_STORE = 2'd2,
    EXC_BUS       = 2'd3
  } lsu_exc_e;

  ////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    lsu_op_e             op;
    logic [DATA_W-1:0]   addr;
    logic [DATA_W-1:0]   wdata;
    logic [REG_AW-1:0]   rd;
  } lsu_req_t;

  typedef struct packed {
    logic [DATA_W-1:0]   rdata;
    logic [REG_AW-1:0]   rd;
    logic                wb_en;    // Register file write
    lsu_exc_e            exc;
    logic [DATA_W-1:0]   exc_addr; // Failing address, zero when no exception
  } lsu_rsp_t;

  typedef struct packed {
    logic                stb;   // Single-cycle access strobe
    logic [DATA_W/8-1:0] we;    // Byte enables, zero for a read
    logic [DATA_W-1:0]   addr;
    logic [DATA_W-1:0]   wdata;
  } dbus_req_t;

  typedef struct packed {
    logic                ack;
    logic [DATA_W-1:0]   rdata;
  } dbus_rsp_t;

  // True for SB, SH and SW
  function automatic logic is_store(lsu_op_e op);
    return op inside {OP_SB, OP_SH, OP_SW};
  endfunction

endpackage

// ==== rtl/bus_wait_timer.sv ====
/*
 * Bus wait timer
 * Counts cycles without acknowledge and flags a bus timeout
 */

`timescale 1ns/100ps

module bus_wait_timer import lsu_pkg::*; (
  input  logic clk_i,
  input  logic rstn_i,
  input  logic start_i,   // Clears and runs the counter
  input  logic stop_i,    // Freezes the counter
  output logic timeout_o
);

  logic [TMR_W-1:0] cnt_q;
  logic             run_q;

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      cnt_q     <= '0;
      run_q     <= 1'b0;
      timeout_o <= 1'b0;
    end else if (start_i) begin
      cnt_q     <= '0;
      run_q     <= 1'b1;
      timeout_o <= 1'b0;                                    // Drop a stale flag
    end else if (stop_i) begin
      run_q     <= 1'b0;
    end else if (run_q) begin
      if (cnt_q != TMR_W'(BUS_TIMEOUT)) cnt_q <= cnt_q + 1'b1; // Saturate
      // Rises BUS_TIMEOUT cycles after start
      if (cnt_q == TMR_W'(BUS_TIMEOUT - 1)) timeout_o <= 1'b1;
    end
  end

endmodule

// ==== rtl/store_align.sv ====
/*
 * Store alignment
 * Checks store alignment and places store data on the byte lanes
 * with the matching byte enables
 */

`timescale 1ns/100ps

module store_align import lsu_pkg::*; (
  input  lsu_op_e             op_i,
  input  logic [DATA_W-1:0]   addr_i,
  input  logic [DATA_W-1:0]   wdata_i,
  output logic [DATA_W-1:0]   data_o,
  output logic [DATA_W/8-1:0] be_o,
  output logic                misaligned_o
);

  logic [1:0] off;

  assign off = addr_i[1:0];

  ////////////////////////////////////////////////////////////
  // Lane placement
  ////////////////////////////////////////////////////////////
  always_comb begin
    data_o       = '0;
    be_o         = '0;    // Loads write nothing
    misaligned_o = 1'b0;
    case (op_i)
      OP_SB: begin
        data_o = {4{wdata_i[7:0]}};                         // Byte on every lane
        be_o   = 4'b0001 << off;
      end
      OP_SH: begin
        data_o       = {2{wdata_i[15:0]}};
        be_o         = off[1] ? 4'b1100 : 4'b0011;
        misaligned_o = off[0];                              // Odd address
      end
      OP_SW: begin
        data_o       = wdata_i;
        be_o         = 4'b1111;
        misaligned_o = |off;
      end
      default: begin
        data_o = '0;
      end
    endcase
    // A misaligned store must not touch memory
    if (misaligned_o) be_o = '0;
  end

endmodule

// ==== rtl/load_extract.sv ====
/*
 * Load extraction
 * Checks load alignment and picks the addressed byte, halfword or
 * word from a read word with sign or zero extension
 */

`timescale 1ns/100ps

module load_extract import lsu_pkg::*; (
  input  lsu_op_e           op_i,
  input  logic [1:0]        off_i,   // Byte offset in the word
  input  logic [DATA_W-1:0] word_i,
  output logic [DATA_W-1:0] data_o,
  output logic              misaligned_o
);

  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  ////////////////////////////////////////////////////////////
  // Lane select
  ////////////////////////////////////////////////////////////
  assign sel_byte = word_i[8*off_i +: 8];
  assign sel_half = off_i[1] ? word_i[31:16] : word_i[15:0];

  ////////////////////////////////////////////////////////////
  // Extension and alignment
  ////////////////////////////////////////////////////////////
  always_comb begin
    data_o       = '0;
    misaligned_o = 1'b0;
    case (op_i)
      OP_LB:  data_o = {{24{sel_byte[7]}}, sel_byte};       // Sign extend
      OP_LBU: data_o = {24'b0, sel_byte};
      OP_LH: begin
        data_o       = {{16{sel_half[15]}}, sel_half};
        misaligned_o = off_i[0];
      end
      OP_LHU: begin
        data_o       = {16'b0, sel_half};
        misaligned_o = off_i[0];
      end
      OP_LW: begin
        data_o       = word_i;
        misaligned_o = |off_i;
      end
      // Store opcodes give nothing here
      default: data_o = '0;
    endcase
  end

endmodule

// ==== rtl/data_ram.sv ====
/*
 * Data RAM
 * Single-port word RAM with byte write enables and a one-cycle ack,
 * silent for addresses outside its range
 */

`timescale 1ns/100ps

module data_ram import lsu_pkg::*; (
  input  logic      clk_i,
  input  logic      rstn_i,
  input  dbus_req_t dbus_req_i,
  output dbus_rsp_t dbus_rsp_o
);

  logic [DATA_W-1:0] mem [RAM_WORDS];
  logic [RAM_AW-1:0] widx;
  logic              in_range;
  logic              hit;
  logic [DATA_W-1:0] rdata_q;
  logic              ack_q;

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////
  assign widx     = dbus_req_i.addr[RAM_AW+1:2];
  assign in_range = ~|dbus_req_i.addr[DATA_W-1:RAM_AW+2]; // Upper bits zero
  assign hit      = dbus_req_i.stb & in_range;

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (hit) begin
      if (|dbus_req_i.we) begin
        for (int b = 0; b < DATA_W/8; b++) begin
          if (dbus_req_i.we[b]) mem[widx][8*b +: 8] <= dbus_req_i.wdata[8*b +: 8];
        end
      end else begin
        rdata_q <= mem[widx];  // Read word
      end
    end
  end

  // Ack one cycle after an in-range strobe, never for a miss
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= hit;
    end
  end

  assign dbus_rsp_o.ack   = ack_q;
  assign dbus_rsp_o.rdata = rdata_q;

endmodule

// ==== rtl/lsu_ctrl_fsm.sv ====
/*
 * LSU control FSM
 * Accepts one request, runs the bus access with a timeout guard,
 * and holds the writeback response until the core takes it
 */

`timescale 1ns/100ps

module lsu_ctrl_fsm import lsu_pkg::*; (
  input  logic                clk_i,
  input  logic                rstn_i,
  input  lsu_req_t            req_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  output lsu_rsp_t            rsp_o,
  output logic                rsp_valid_o,
  input  logic                rsp_ready_i,
  input  logic [DATA_W-1:0]   st_data_i,   // Lane-placed store data
  input  logic [DATA_W/8-1:0] st_be_i,
  input  logic                st_mis_i,
  input  logic [DATA_W-1:0]   ld_data_i,   // Extended load result
  input  logic                ld_mis_i,
  output logic [DATA_W-1:0]   ld_word_o,
  output lsu_op_e             ld_op_o,
  output logic [1:0]          ld_off_o,
  output dbus_req_t           dbus_req_o,
  input  dbus_rsp_t           dbus_rsp_i,
  output logic                tmr_start_o,
  output logic                tmr_stop_o,
  input  logic                tmr_timeout_i
);

  lsu_state_e          state_q, state_d;
  logic                accept;

  // Registered request, no reset needed
  lsu_op_e             op_q;
  logic [DATA_W-1:0]   addr_q;
  logic [REG_AW-1:0]   rd_q;
  logic [DATA_W-1:0]   wdata_q;
  logic [DATA_W/8-1:0] be_q;
  logic [DATA_W-1:0]   word_q;    // Read word from the RAM
  lsu_exc_e            exc_q;

  assign accept = req_valid_i & req_ready_o;

  ////////////////////////////////////////////////////////////
  // State sequencing
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (accept) state_d = (st_mis_i | ld_mis_i) ? ST_RESP : ST_BUS;
      ST_BUS:  state_d = ST_WAIT;                                // Strobe is one cycle
      ST_WAIT: if (dbus_rsp_i.ack | tmr_timeout_i) state_d = ST_RESP;
      ST_RESP: if (rsp_ready_i) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Request and result capture
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q    <= req_i.op;
      addr_q  <= req_i.addr;
      rd_q    <= req_i.rd;
      wdata_q <= st_data_i;
      be_q    <= st_be_i;
      if (st_mis_i)      exc_q <= EXC_MIS_STORE;
      else if (ld_mis_i) exc_q <= EXC_MIS_LOAD;
      else               exc_q <= EXC_NONE;
    end else if (state_q == ST_WAIT) begin
      if (dbus_rsp_i.ack)     word_q <= dbus_rsp_i.rdata; // Ack wins over a late timeout
      else if (tmr_timeout_i) exc_q  <= EXC_BUS;
    end
  end

  // Alignment check on the live request, extraction on the stored word
  assign ld_op_o   = (state_q == ST_IDLE) ? req_i.op        : op_q;
  assign ld_off_o  = (state_q == ST_IDLE) ? req_i.addr[1:0] : addr_q[1:0];
  assign ld_word_o = word_q;

  ////////////////////////////////////////////////////////////
  // Bus and timer
  ////////////////////////////////////////////////////////////
  assign dbus_req_o.stb   = (state_q == ST_BUS);
  assign dbus_req_o.we    = dbus_req_o.stb ? be_q : '0;     // Enables only with the strobe
  assign dbus_req_o.addr  = addr_q;
  assign dbus_req_o.wdata = wdata_q;

  assign tmr_start_o = (state_q == ST_BUS);
  assign tmr_stop_o  = (state_q == ST_WAIT) & (dbus_rsp_i.ack | tmr_timeout_i);

  ////////////////////////////////////////////////////////////
  // Handshakes and response
  ////////////////////////////////////////////////////////////
  assign req_ready_o = (state_q == ST_IDLE); // One request in flight
  assign rsp_valid_o = (state_q == ST_RESP);

  assign rsp_o.wb_en    = ~is_store(op_q) & (exc_q == EXC_NONE);
  assign rsp_o.rdata    = rsp_o.wb_en ? ld_data_i : '0;
  assign rsp_o.rd       = rd_q;
  assign rsp_o.exc      = exc_q;
  assign rsp_o.exc_addr = (exc_q != EXC_NONE) ? addr_q : '0;

endmodule

// ==== rtl/lsu_top.sv ====
/*
 * Load-store subsystem top level
 * Control FSM, bus wait timer, store and load data paths and data RAM
 */

`timescale 1ns/100ps

module lsu_top import lsu_pkg::*; (
  input  logic     clk_i,
  input  logic     rstn_i,
  input  lsu_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  output lsu_rsp_t rsp_o,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i
);

  dbus_req_t           dbus_req;
  dbus_rsp_t           dbus_rsp;
  logic                tmr_start, tmr_stop, tmr_timeout;
  logic [DATA_W-1:0]   st_data;
  logic [DATA_W/8-1:0] st_be;
  logic                st_mis;
  logic [DATA_W-1:0]   ld_data;
  logic                ld_mis;
  logic [DATA_W-1:0]   ld_word;
  lsu_op_e             ld_op;
  logic [1:0]          ld_off;

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////
  lsu_ctrl_fsm lsu_ctrl_fsm_i (
    .clk_i, .rstn_i,
    .req_i, .req_valid_i, .req_ready_o,
    .rsp_o, .rsp_valid_o, .rsp_ready_i,
    .st_data_i (st_data), .st_be_i (st_be), .st_mis_i (st_mis),
    .ld_data_i (ld_data), .ld_mis_i (ld_mis),
    .ld_word_o (ld_word), .ld_op_o (ld_op), .ld_off_o (ld_off),
    .dbus_req_o (dbus_req), .dbus_rsp_i (dbus_rsp),
    .tmr_start_o (tmr_start), .tmr_stop_o (tmr_stop), .tmr_timeout_i (tmr_timeout)
  );

  bus_wait_timer bus_wait_timer_i (
    .clk_i, .rstn_i,
    .start_i   (tmr_start),
    .stop_i    (tmr_stop),
    .timeout_o (tmr_timeout)
  );

  ////////////////////////////////////////////////////////////
  // Data paths and memory
  ////////////////////////////////////////////////////////////
  store_align store_align_i (   // Sees the live request
    .op_i (req_i.op), .addr_i (req_i.addr), .wdata_i (req_i.wdata),
    .data_o (st_data), .be_o (st_be), .misaligned_o (st_mis)
  );

  load_extract load_extract_i (
    .op_i (ld_op), .off_i (ld_off), .word_i (ld_word),
    .data_o (ld_data), .misaligned_o (ld_mis)
  );

  data_ram data_ram_i (
    .clk_i, .rstn_i,
    .dbus_req_i (dbus_req),
    .dbus_rsp_o (dbus_rsp)
  );

endmodule

// ==== test/lsu_chk.sv ====
/*
 * LSU protocol checker
 * Bound to the top level; checks response hold under back-pressure,
 * channel exclusion, strobe width and writeback rules
 */

`timescale 1ns/100ps

module lsu_chk import lsu_pkg::*; (
  input logic     clk_i,
  input logic     rstn_i,
  input logic     req_ready_i,
  input lsu_rsp_t rsp_i,
  input logic     rsp_valid_i,
  input logic     rsp_ready_i,
  input logic     stb_i        // Data bus strobe
);

  ////////////////////////////////////////////////////////////
  // Core side handshakes
  ////////////////////////////////////////////////////////////
  // Stalled response keeps valid and every field
  rsp_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
    else $error("Response changed or dropped while stalled");

  chan_excl: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !(req_ready_i && rsp_valid_i))                          // One request in flight
    else $error("Request ready while a response is pending");

  ////////////////////////////////////////////////////////////
  // Bus and response fields
  ////////////////////////////////////////////////////////////
  stb_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
    stb_i |=> !stb_i)
    else $error("Bus strobe held longer than one cycle");

  wb_no_exc: assert property (@(posedge clk_i) disable iff (!rstn_i)
    rsp_valid_i && rsp_i.wb_en |-> rsp_i.exc == EXC_NONE)
    else $error("Writeback enabled on a response with an exception");

endmodule

// ==== test/lsu_tb.sv ====
/*
 * Load-store subsystem testbench
 * Reference byte memory and expected responses, directed lane,
 * alignment and bus error tests, back-pressure and a random mix
 */

`timescale 1ns/100ps

module lsu_tb import lsu_pkg::*; ();

  localparam int RST_CYCLES  = 16;
  localparam int BYTE_AW     = RAM_AW + 2;
  localparam int MEM_BYTES   = RAM_WORDS * 4;
  localparam int N_LANE      = 7 * 21;   // Seven stores, twenty loads after each
  localparam int N_MIS       = 2 * 12;   // Misaligned access plus check load
  localparam int N_BUS       = 2 * 3;
  localparam int N_BP        = 40;
  localparam int N_RAND      = 300;
  localparam int N_REQ       = RAM_WORDS + N_LANE + N_MIS + N_BUS + N_BP + N_RAND;
  localparam int CYCLE_LIMIT = N_REQ * (BUS_TIMEOUT + 20) + RST_CYCLES;
  localparam logic [DATA_W-1:0] LANE_BASE = 32'h0000_0100;
  localparam logic [DATA_W-1:0] MIS_BASE  = 32'h0000_0200;

  logic     clk_i;
  logic     rstn_i;
  lsu_req_t req;
  logic     req_valid, req_ready;
  lsu_rsp_t rsp;
  logic     rsp_valid, rsp_ready;

  logic [7:0]  ref_mem [MEM_BYTES];   // Mirror of the data RAM, byte wide
  lsu_rsp_t    exp_q [$];             // Expected responses in request order
  string       name_q [$];            // Test name of each expected response
  int          err_val   = 0;
  int          err_other = 0;
  int          n_sent    = 0;
  int          n_got     = 0;
  int          cycles    = 0;
  string       test_name = "reset";
  logic        rand_ready = 1'b0;      // Random back-pressure on the response

  lsu_op_e     st_ops  [3] = '{OP_SB, OP_SH, OP_SW};
  lsu_op_e     ld_ops  [5] = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
  lsu_op_e     mis_ops [5] = '{OP_SH, OP_SW, OP_LH, OP_LHU, OP_LW};
  logic [31:0] bus_addrs [3] = '{32'h0000_0400, 32'h8000_0000, 32'hFFFF_FFFC};

  lsu_top lsu_top_i (
    .clk_i, .rstn_i,
    .req_i (req), .req_valid_i (req_valid), .req_ready_o (req_ready),
    .rsp_o (rsp), .rsp_valid_o (rsp_valid), .rsp_ready_i (rsp_ready)
  );

  bind lsu_top lsu_chk lsu_chk_i (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .req_ready_i (req_ready_o),
    .rsp_i       (rsp_o),
    .rsp_valid_i (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .stb_i       (dbus_req.stb)
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;            // 100 ns period

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////
  function automatic int size_of(lsu_op_e op);
    case (op)
      OP_LB, OP_LBU, OP_SB: return 1;
      OP_LH, OP_LHU, OP_SH: return 2;
      default:              return 4;
    endcase
  endfunction

  function automatic bit writes_mem(lsu_op_e op);
    return (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
  endfunction

  // Expected response; aligned in-range stores also update the mirror
  function automatic lsu_rsp_t ref_rsp(lsu_req_t r);
    lsu_rsp_t           e;
    int                 n;
    logic [31:0]        val;
    logic [BYTE_AW-1:0] ba;
    n     = size_of(r.op);
    e     = '0;
    e.rd  = r.rd;
    e.exc = EXC_NONE;
    if ((r.addr[1:0] & 2'(n - 1)) != 2'b00) begin
      e.exc = writes_mem(r.op) ? EXC_MIS_STORE : EXC_MIS_LOAD;
    end else if (r.addr >= MEM_BYTES) begin
      e.exc = EXC_BUS;                                      // Nobody answers up there
    end
    if (e.exc != EXC_NONE) begin
      e.exc_addr = r.addr;
    end else begin
      val = '0;
      for (int i = 0; i < n; i++) begin
        ba = r.addr[BYTE_AW-1:0] + BYTE_AW'(i);             // Little endian
        if (writes_mem(r.op)) ref_mem[ba] = r.wdata[8*i +: 8];
        else                  val[8*i +: 8] = ref_mem[ba];
      end
      case (r.op)
        OP_LB:   val = {{24{val[7]}}, val[7:0]};
        OP_LH:   val = {{16{val[15]}}, val[15:0]};
        default: ;                                          // Zero extended already
      endcase
      if (!writes_mem(r.op)) begin
        e.wb_en = 1'b1;
        e.rdata = val;
      end
    end
    return e;
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////
  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      err_val++;
      $display("Fail %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_field(string name, string field, logic [31:0] exp, logic [31:0] act);
    if (act !== exp) begin
      err_val++;
      $display("Fail %s %s: expected %h, actual %h", name, field, exp, act);
    end
  endtask

  task automatic check_rsp(string name, lsu_rsp_t exp, lsu_rsp_t act);
    check_field(name, "rdata", exp.rdata, act.rdata);
    check_field(name, "rd", 32'(exp.rd), 32'(act.rd));
    check_field(name, "wb_en", 32'(exp.wb_en), 32'(act.wb_en));
    check_field(name, "exc", 32'(exp.exc), 32'(act.exc));
    check_field(name, "exc_addr", exp.exc_addr, act.exc_addr);
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] fill_word(logic [31:0] a);
    return (a * 32'h9E37_79B1) ^ 32'hC3A5_0F1E;           // Differs for every address
  endfunction

  function automatic lsu_req_t make_req(lsu_op_e op, logic [31:0] addr, logic [31:0] wdata);
    lsu_req_t r;
    r.op    = op;
    r.addr  = addr;
    r.wdata = wdata;
    r.rd    = REG_AW'($urandom);
    return r;
  endfunction

  function automatic lsu_req_t rand_req();
    lsu_op_e     op;
    logic [31:0] addr;
    int          n;
    op = lsu_op_e'(3'($urandom_range(0, 7)));
    n  = size_of(op);
    if ($urandom_range(0, 9) == 0) addr = $urandom | 32'h0000_0400; // Out of range
    else                           addr = 32'($urandom_range(0, MEM_BYTES - 1));
    if ($urandom_range(0, 3) != 0) addr = addr & ~32'(n - 1);       // Mostly aligned
    return make_req(op, addr, $urandom);
  endfunction

  // Issue one request on the falling edge; optionally time the response
  task automatic send(lsu_req_t r, bit timed);
    lsu_rsp_t exp;
    int       lat;
    exp = ref_rsp(r);
    lat = (exp.exc == EXC_NONE) ? 3 : 1;                    // Bus access or alignment fault
    @(negedge clk_i);
    while (req_ready !== 1'b1) @(negedge clk_i);
    req       = r;
    req_valid = 1'b1;
    exp_q.push_back(exp);
    name_q.push_back(test_name);
    n_sent++;
    for (int k = 1; k <= (timed ? lat : 1); k++) begin
      @(negedge clk_i);
      req_valid = 1'b0;
      if (timed) check_bit({test_name, " rsp latency"}, k == lat, rsp_valid);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Response monitor
  ////////////////////////////////////////////////////////////
  // Sampled at the falling edge ahead of the transfer edge
  initial begin : monitor
    lsu_rsp_t held;
    logic     held_valid;
    lsu_rsp_t exp;
    held       = '0;
    held_valid = 1'b0;
    rsp_ready  = 1'b1;
    forever begin
      @(negedge clk_i);
      if (held_valid) begin                                 // Stalled last cycle
        check_bit("hold rsp_valid", 1'b1, rsp_valid);
        check_rsp("hold", held, rsp);
      end
      if (rsp_valid === 1'b1) check_bit("busy req_ready", 1'b0, req_ready);
      rsp_ready = rand_ready ? ($urandom_range(0, 1) == 1) : 1'b1;
      if (rsp_valid === 1'b1 && rsp_ready) begin
        if (exp_q.size() == 0) begin
          err_other++;
          $display("A response arrived with no request outstanding");
        end else begin
          exp = exp_q.pop_front();
          check_rsp(name_q.pop_front(), exp, rsp);
          n_got++;
        end
        held_valid = 1'b0;
      end else begin
        held_valid = (rsp_valid === 1'b1);
        held       = rsp;
      end
    end
  end

  // Run limit
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run stopped at the cycle limit with %0d of %0d responses received",
               n_got, n_sent);
      $display("Errors: %0d wrong values, %0d other failures", err_val, err_other + 1);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial begin : stimulus
    void'($urandom(81130));
    rstn_i    = 1'b0;
    req       = '0;
    req_valid = 1'b0;
    repeat (RST_CYCLES) @(negedge clk_i);
    rstn_i = 1'b1;
    @(negedge clk_i);
    check_bit("reset req_ready", 1'b1, req_ready);
    check_bit("reset rsp_valid", 1'b0, rsp_valid);

    // RAM has no reset, so fill it first
    test_name = "fill";
    for (int w = 0; w < RAM_WORDS; w++) begin
      send(make_req(OP_SW, 32'(w * 4), fill_word(32'(w * 4))), 0);
    end

    test_name = "lanes";
    foreach (st_ops[s]) begin
      for (int o = 0; o < 4; o += size_of(st_ops[s])) begin
        send(make_req(st_ops[s], LANE_BASE + 32'(o), $urandom | 32'h0000_8080), 1);
        foreach (ld_ops[l]) begin
          for (int p = 0; p < 4; p++) send(make_req(ld_ops[l], LANE_BASE + 32'(p), 32'h0), 1);
        end
      end
    end

    test_name = "misaligned";
    for (int o = 1; o < 4; o++) begin
      foreach (mis_ops[m]) begin
        if (size_of(mis_ops[m]) == 4 || (o % 2) == 1) begin
          send(make_req(mis_ops[m], MIS_BASE + 32'(o), $urandom), 1);
          send(make_req(OP_LW, MIS_BASE, 32'h0), 1);        // Word must be untouched
        end
      end
    end

    test_name = "bus_error";
    foreach (bus_addrs[b]) begin
      send(make_req((b == 1) ? OP_SW : OP_LW, bus_addrs[b], $urandom), 0);
      send(make_req(OP_LW, 32'h0000_03FC, 32'h0), 1);
    end

    test_name  = "backpressure";
    rand_ready = 1'b1;
    repeat (N_BP) send(rand_req(), 0);

    test_name  = "random";
    rand_ready = 1'b0;
    repeat (N_RAND) send(rand_req(), 0);

    while (exp_q.size() != 0) @(negedge clk_i);
    repeat (4) @(negedge clk_i);
    $display("Errors: %0d wrong values, %0d other failures", err_val, err_other);
    if (err_val + err_other == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== lsu_top.f ====
rtl/lsu_pkg.sv
rtl/bus_wait_timer.sv
rtl/store_align.sv
rtl/load_extract.sv
rtl/data_ram.sv
rtl/lsu_ctrl_fsm.sv
rtl/lsu_top.sv
test/lsu_chk.sv
test/lsu_tb.sv

// ==== Makefile ====
# Verilator flow for the load-store subsystem

FLIST := lsu_top.f
TOP   := lsu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f $(FLIST)

# The log decides the result; a missing pass line also counts as failure
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "CHECKS FAILED" sim.log; then \
	  echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "ALL CHECKS PASSED" sim.log; then \
	  echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
